// File: sim.f
+incdir+source
source/matmul_pkg.sv
source/operand_mem.sv
source/mem_arbiter.sv
source/dot_engine.sv
source/job_scheduler.sv
source/matmul_top.sv
tests/matmul_assertions.sv
tests/matmul_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the matmul testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -f sim.f --top-module matmul_tb \
    --Mdir "$BUILD_DIR" -o matmul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/matmul_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation passed"
exit 0

// File: tests/matmul_cases.txt
// one record per line: A[0][0..3] A[1][0..3] A[2][0..3] (12 words), then
// B_T[0][0..3] B_T[1][0..3] (8 words), then expected C[0][0] C[0][1] .. C[2][1] (6 words)
1 2 3 4 5 6 7 8 9 a b c 1 0 0 0 0 1 1 1 1 9 5 15 9 21
2 2 2 2 1 0 1 0 10 20 30 40 1 1 1 1 3 0 0 2 8 a 2 3 a0 b0
ffffffff 0 0 0 80000000 80000000 0 0 10000 0 0 1 2 0 0 0 ffffffff 2 0 10000 fffffffe 1 0 80000000 20000 0

// File: tests/matmul_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module matmul_tb;

    localparam int L      = `MATMUL_L;
    localparam int M      = `MATMUL_M;
    localparam int N      = `MATMUL_N;
    localparam int DEPTH  = `MATMUL_DEPTH;
    localparam int ADDR_W = `MATMUL_ADDR_W;
    localparam int ELEMS  = L * N;
    // a record holds A, then B_T, then C in row-major order
    localparam int REC_W      = DEPTH + ELEMS;
    localparam int FILE_CASES = 3;
    localparam int RAND_CASES = 2;
    // the aborted run and the run after it count as two more cases
    localparam int ALL_CASES  = FILE_CASES + RAND_CASES + 2;
    localparam int LIMIT      = ALL_CASES * (DEPTH + ELEMS * (2 * M + 6)) * 2 + 100;

    logic                   vector_mult_done;
    logic                   reset;
    logic                   load;
    matmul_pkg::mem_write_t load_word;
    logic                   start;
    logic                   result_valid;
    matmul_pkg::result_t    result;
    logic                   done;

    logic [31:0] case_words [FILE_CASES * REC_W];
    logic [31:0] operand [DEPTH];
    logic [31:0] expected [ELEMS];
    // scoreboard indexed by row * N + col
    logic [31:0] got_value [ELEMS];
    int          got_count [ELEMS];
    int          received = 0;
    int          done_count = 0;
    int          last_result_cycle = 0;
    int          cycle_count = 0;
    int          value_errors = 0;
    int          tag_errors = 0;
    int          done_errors = 0;
    logic [31:0] lcg_state;

    matmul_top DUT (
        .vector_mult_done(vector_mult_done), .reset(reset),
        .load(load), .load_word(load_word), .start(start),
        .result_valid(result_valid), .result(result), .done(done)
    );

    always #10 vector_mult_done = ~vector_mult_done;

    // watchdog sized from the number of runs and the worst expected run length
    always @(posedge vector_mult_done) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= LIMIT) begin
            $display("ERROR: the run did not finish within %0d cycles", LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    // outputs are registered on the rising edge, so they are sampled on the falling one
    always @(negedge vector_mult_done) begin
        int idx;
        if (result_valid) begin
            if (int'(result.row) < L && int'(result.col) < N) begin
                idx = int'(result.row) * N + int'(result.col);
                got_value[idx] = result.value;
                got_count[idx]++;
            end else begin
                tag_errors++;
                $display("ERROR: result tag (%0d,%0d) lies outside C at %0t",
                         result.row, result.col, $time);
            end
            received++;
            last_result_cycle = cycle_count;
        end
        if (done) begin
            done_count++;
            // done belongs one cycle after the last of all L*N results
            assert (received == ELEMS && cycle_count == last_result_cycle + 1) else begin
                done_errors++;
                $display("ERROR: done pulsed after %0d of %0d results at %0t",
                         received, ELEMS, $time);
            end
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // C[r][c] is the dot product of row r of A and row c of B_T, wrapping at 32 bits
    function automatic logic [31:0] dot_ref(input int r, input int c);
        logic [31:0] sum;
        sum = '0;
        for (int k = 0; k < M; k++) begin
            sum = sum + operand[r * M + k] * operand[L * M + c * M + k];
        end
        return sum;
    endfunction

    task automatic fill_from_file(input int n);
        for (int i = 0; i < DEPTH; i++) begin
            operand[i] = case_words[n * REC_W + i];
        end
        for (int i = 0; i < ELEMS; i++) begin
            expected[i] = case_words[n * REC_W + DEPTH + i];
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < DEPTH; i++) begin
            lcg_state  = lcg_next(lcg_state);
            operand[i] = lcg_state;
        end
        for (int i = 0; i < ELEMS; i++) begin
            expected[i] = dot_ref(i / N, i % N);
        end
    endtask

    task automatic clear_scoreboard();
        for (int i = 0; i < ELEMS; i++) begin
            got_count[i] = 0;
            got_value[i] = '0;
        end
        received   = 0;
        done_count = 0;
    endtask

    // every word is rewritten, so nothing of the previous operands survives
    task automatic load_operands();
        for (int i = 0; i < DEPTH; i++) begin
            @(posedge vector_mult_done);
            #2;
            load           = 1'b1;
            load_word.addr = ADDR_W'(i);
            load_word.data = operand[i];
        end
        @(posedge vector_mult_done);
        #2;
        load = 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge vector_mult_done);
        #2;
        start = 1'b1;
        @(posedge vector_mult_done);
        #2;
        start = 1'b0;
    endtask

    task automatic check_results(input string name);
        for (int i = 0; i < ELEMS; i++) begin
            assert (got_count[i] == 1) else begin
                tag_errors++;
                $display("ERROR: %s element (%0d,%0d) arrived %0d times",
                         name, i / N, i % N, got_count[i]);
            end
            if (got_count[i] > 0) begin
                assert (got_value[i] == expected[i]) else begin
                    value_errors++;
                    $display("FAILED time=%0t signal=result.value C[%0d][%0d] expected=%h actual=%h",
                             $time, i / N, i % N, expected[i], got_value[i]);
                end
            end
        end
        assert (done_count == 1) else begin
            done_errors++;
            $display("ERROR: %s saw done %0d times instead of once", name, done_count);
        end
    endtask

    task automatic run_case(input string name, input logic restart);
        clear_scoreboard();
        load_operands();
        pulse_start();
        if (restart) begin
            // a second start while the engines are busy must change nothing
            repeat (5) @(posedge vector_mult_done);
            pulse_start();
        end
        while (done_count == 0) begin
            @(negedge vector_mult_done);
        end
        // linger a while to catch a stray result or a second done
        repeat (2 * M + 6) @(negedge vector_mult_done);
        check_results(name);
    endtask

    task automatic abort_run();
        fill_random();
        clear_scoreboard();
        load_operands();
        pulse_start();
        while (received < 2) begin
            @(negedge vector_mult_done);
        end
        @(posedge vector_mult_done);
        #2;
        reset = 1'b1;
        @(posedge vector_mult_done);
        clear_scoreboard();
        repeat (9) begin
            @(negedge vector_mult_done);
            assert (!result_valid && !done) else begin
                done_errors++;
                $display("ERROR: result_valid or done was high during reset at %0t", $time);
            end
        end
        @(posedge vector_mult_done);
        #2;
        reset = 1'b0;
        repeat (4 * M + 12) @(negedge vector_mult_done);
        assert (received == 0 && done_count == 0) else begin
            done_errors++;
            $display("ERROR: outputs came alive after reset without a new start");
        end
    endtask

    initial begin
        vector_mult_done = 1'b0;
        reset            = 1'b1;
        load             = 1'b0;
        load_word        = '0;
        start            = 1'b0;
        lcg_state        = 32'h6af8;
        $readmemh("tests/matmul_cases.txt", case_words);
        repeat (10) @(posedge vector_mult_done);
        #2;
        reset = 1'b0;

        // the first file case also gets a second start in mid-run
        for (int n = 0; n < FILE_CASES; n++) begin
            fill_from_file(n);
            run_case("file case", n == 0);
        end
        for (int n = 0; n < RAND_CASES; n++) begin
            fill_random();
            run_case("random case", 1'b0);
        end
        abort_run();
        fill_from_file(FILE_CASES - 1);
        run_case("run after reset", 1'b0);

        $display("errors: value=%0d count_or_tag=%0d done_or_reset=%0d protocol=%0d",
                 value_errors, tag_errors, done_errors, DUT.protocol_checks.failures);
        if (value_errors == 0 && tag_errors == 0 && done_errors == 0
            && DUT.protocol_checks.failures == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/matmul_assertions.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module matmul_assertions (
    input wire logic                       vector_mult_done,
    input wire logic                       reset,
    input wire logic                       result_valid,
    input wire logic                       done,
    input wire matmul_pkg::mem_read_req_t  req_0,
    input wire matmul_pkg::mem_read_req_t  req_1,
    input wire logic                       read_en,
    input wire logic [`MATMUL_ADDR_W-1:0]  read_addr,
    input wire matmul_pkg::mem_read_rsp_t  rsp_0,
    input wire matmul_pkg::mem_read_rsp_t  rsp_1,
    input wire logic                       result_ready_0,
    input wire logic                       result_ready_1,
    input wire logic                       result_ack_0,
    input wire logic                       result_ack_1,
    input wire matmul_pkg::result_t        eng_result_0,
    input wire matmul_pkg::result_t        eng_result_1
);

    // number of protocol violations seen so far
    int failures = 0;

    // every grant serves one engine only, so read data that reaches an engine
    // must come from a read issued the cycle before at that engine's own address
    grant_route_0: assert property (@(posedge vector_mult_done) disable iff (reset)
        rsp_0.valid |-> $past(read_en && req_0.req && (read_addr == req_0.addr)))
        else begin
            failures = failures + 1;
            $error("engine 0 received data that was not read for it");
        end

    grant_route_1: assert property (@(posedge vector_mult_done) disable iff (reset)
        rsp_1.valid |-> $past(read_en && req_1.req && (read_addr == req_1.addr)))
        else begin
            failures = failures + 1;
            $error("engine 1 received data that was not read for it");
        end

    // done marks the end of a run and lasts exactly one cycle
    done_pulse: assert property (@(posedge vector_mult_done) disable iff (reset)
        done |=> !done)
        else begin
            failures = failures + 1;
            $error("done stayed high for more than one cycle");
        end

    // the outputs are registered, so they are low from the first edge after reset
    quiet_in_reset: assert property (@(posedge vector_mult_done)
        reset |=> (!result_valid && !done))
        else begin
            failures = failures + 1;
            $error("result_valid or done was high while reset was held");
        end

    // an engine in HOLD keeps its tagged result until the scheduler takes it
    hold_stable_0: assert property (@(posedge vector_mult_done) disable iff (reset)
        (result_ready_0 && !result_ack_0) |=> (result_ready_0 && $stable(eng_result_0)))
        else begin
            failures = failures + 1;
            $error("engine 0 changed or dropped its result before the ack");
        end

    hold_stable_1: assert property (@(posedge vector_mult_done) disable iff (reset)
        (result_ready_1 && !result_ack_1) |=> (result_ready_1 && $stable(eng_result_1)))
        else begin
            failures = failures + 1;
            $error("engine 1 changed or dropped its result before the ack");
        end

endmodule

bind matmul_top matmul_assertions protocol_checks (
    .vector_mult_done(vector_mult_done), .reset(reset),
    .result_valid(result_valid), .done(done),
    .req_0(req_0), .req_1(req_1),
    .read_en(read_en), .read_addr(read_addr),
    .rsp_0(rsp_0), .rsp_1(rsp_1),
    .result_ready_0(result_ready_0), .result_ready_1(result_ready_1),
    .result_ack_0(result_ack_0), .result_ack_1(result_ack_1),
    .eng_result_0(eng_result_0), .eng_result_1(eng_result_1)
);

`default_nettype wire

// File: source/matmul_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module matmul_top (
    input  wire logic                    vector_mult_done,
    input  wire logic                    reset,
    input  wire logic                    load,
    input  wire matmul_pkg::mem_write_t  load_word,
    input  wire logic                    start,
    output logic                         result_valid,
    output matmul_pkg::result_t          result,
    output logic                         done
);

    // shared memory read port after arbitration
    logic                       read_en;
    logic [`MATMUL_ADDR_W-1:0]  read_addr;
    logic [`MATMUL_DATA_W-1:0]  read_data;

    // per engine request and response paths
    matmul_pkg::mem_read_req_t  req_0;
    matmul_pkg::mem_read_req_t  req_1;
    matmul_pkg::mem_read_rsp_t  rsp_0;
    matmul_pkg::mem_read_rsp_t  rsp_1;

    // scheduler to engine job dispatch, one job bus shared by both engines
    matmul_pkg::engine_job_t    job;
    logic                       job_valid_0;
    logic                       job_valid_1;
    logic                       busy_0;
    logic                       busy_1;

    // engine results waiting for the scheduler
    matmul_pkg::result_t        eng_result_0;
    matmul_pkg::result_t        eng_result_1;
    logic                       result_ready_0;
    logic                       result_ready_1;
    logic                       result_ack_0;
    logic                       result_ack_1;

    operand_mem mem (
        .vector_mult_done(vector_mult_done), .reset(reset),
        .write_valid(load), .write(load_word),
        .read_en(read_en), .read_addr(read_addr), .read_data(read_data)
    );

    mem_arbiter arbiter (
        .vector_mult_done(vector_mult_done), .reset(reset),
        .req_0(req_0), .req_1(req_1), .rsp_0(rsp_0), .rsp_1(rsp_1),
        .read_en(read_en), .read_addr(read_addr), .read_data(read_data)
    );

    dot_engine engine_0 (
        .vector_mult_done(vector_mult_done), .reset(reset),
        .job_valid(job_valid_0), .job(job), .busy(busy_0),
        .mem_req(req_0), .mem_rsp(rsp_0),
        .result_ready(result_ready_0), .result(eng_result_0), .result_ack(result_ack_0)
    );

    dot_engine engine_1 (
        .vector_mult_done(vector_mult_done), .reset(reset),
        .job_valid(job_valid_1), .job(job), .busy(busy_1),
        .mem_req(req_1), .mem_rsp(rsp_1),
        .result_ready(result_ready_1), .result(eng_result_1), .result_ack(result_ack_1)
    );

    job_scheduler scheduler (
        .vector_mult_done(vector_mult_done), .reset(reset), .start(start),
        .job_valid_0(job_valid_0), .job_valid_1(job_valid_1), .job(job),
        .busy_0(busy_0), .busy_1(busy_1),
        .result_ready_0(result_ready_0), .result_ready_1(result_ready_1),
        .result_0(eng_result_0), .result_1(eng_result_1),
        .result_ack_0(result_ack_0), .result_ack_1(result_ack_1),
        .result_valid(result_valid), .result(result), .done(done)
    );

endmodule

`default_nettype wire

// File: source/job_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module job_scheduler (
    input  wire logic                     vector_mult_done,
    input  wire logic                     reset,
    input  wire logic                     start,
    output logic                          job_valid_0,
    output logic                          job_valid_1,
    output matmul_pkg::engine_job_t       job,
    input  wire logic                     busy_0,
    input  wire logic                     busy_1,
    input  wire logic                     result_ready_0,
    input  wire logic                     result_ready_1,
    input  wire matmul_pkg::result_t      result_0,
    input  wire matmul_pkg::result_t      result_1,
    output logic                          result_ack_0,
    output logic                          result_ack_1,
    output logic                          result_valid,
    output matmul_pkg::result_t           result,
    output logic                          done
);

    localparam int TOTAL = `MATMUL_L * `MATMUL_N;
    localparam int CNT_W = $clog2(TOTAL + 1);

    matmul_pkg::sched_state_e state;

    // next (row, col) to hand out, walked in row-major order
    logic [`MATMUL_ROW_W-1:0] next_row;
    logic [`MATMUL_COL_W-1:0] next_col;
    logic                     all_issued;
    logic [CNT_W-1:0]         acked;
    logic                     issue;
    logic                     last_job;

    // a new job goes to an idle engine, engine 0 first, one job per cycle
    assign job_valid_0 = (state == matmul_pkg::SCHED_RUN) && !all_issued && !busy_0;
    assign job_valid_1 = (state == matmul_pkg::SCHED_RUN) && !all_issued && !busy_1
                         && !job_valid_0;
    assign issue       = job_valid_0 || job_valid_1;
    assign job.row     = next_row;
    assign job.col     = next_col;
    assign last_job    = (next_row == `MATMUL_ROW_W'(`MATMUL_L - 1))
                         && (next_col == `MATMUL_COL_W'(`MATMUL_N - 1));

    // one result per cycle, and engine 0 wins when both are waiting
    assign result_ack_0 = (state == matmul_pkg::SCHED_RUN) && result_ready_0;
    assign result_ack_1 = (state == matmul_pkg::SCHED_RUN) && result_ready_1
                          && !result_ready_0;

    always_ff @(posedge vector_mult_done) begin
        if (reset) begin
            state        <= matmul_pkg::SCHED_IDLE;
            next_row     <= '0;
            next_col     <= '0;
            all_issued   <= 1'b0;
            acked        <= '0;
            result_valid <= 1'b0;
            done         <= 1'b0;
        end else begin
            result_valid <= result_ack_0 || result_ack_1;
            // done rises the cycle after the last result_valid and lasts one cycle
            done         <= (state == matmul_pkg::SCHED_FINISH);
            case (state)
                matmul_pkg::SCHED_IDLE: begin
                    if (start) begin
                        state      <= matmul_pkg::SCHED_RUN;
                        next_row   <= '0;
                        next_col   <= '0;
                        all_issued <= 1'b0;
                        acked      <= '0;
                    end
                end
                matmul_pkg::SCHED_RUN: begin
                    // start is not looked at here, a second strobe mid-run has no effect
                    if (issue) begin
                        if (last_job) begin
                            all_issued <= 1'b1;
                        end else if (next_col == `MATMUL_COL_W'(`MATMUL_N - 1)) begin
                            next_col <= '0;
                            next_row <= next_row + 1'b1;
                        end else begin
                            next_col <= next_col + 1'b1;
                        end
                    end
                    if (result_ack_0 || result_ack_1) begin
                        acked <= acked + 1'b1;
                        if (acked == CNT_W'(TOTAL - 1)) begin
                            state <= matmul_pkg::SCHED_FINISH;
                        end
                    end
                end
                default: begin
                    state <= matmul_pkg::SCHED_IDLE;
                end
            endcase
        end
    end

    // the tagged element is registered together with result_valid
    always_ff @(posedge vector_mult_done) begin
        if (result_ack_0) begin
            result <= result_0;
        end else if (result_ack_1) begin
            result <= result_1;
        end
    end

endmodule

`default_nettype wire

// File: source/dot_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module dot_engine (
    input  wire logic                       vector_mult_done,
    input  wire logic                       reset,
    input  wire logic                       job_valid,
    input  wire matmul_pkg::engine_job_t    job,
    output logic                            busy,
    output matmul_pkg::mem_read_req_t       mem_req,
    input  wire matmul_pkg::mem_read_rsp_t  mem_rsp,
    output logic                            result_ready,
    output matmul_pkg::result_t             result,
    input  wire logic                       result_ack
);

    localparam int ADDR_W = `MATMUL_ADDR_W;
    localparam int K_W    = (`MATMUL_M > 1) ? $clog2(`MATMUL_M) : 1;

    matmul_pkg::engine_state_e state;
    matmul_pkg::engine_job_t   cur_job;

    // k walks along the shared inner dimension
    logic [K_W-1:0]            k;
    logic [`MATMUL_DATA_W-1:0] a_val;
    logic [`MATMUL_DATA_W-1:0] b_val;
    logic [`MATMUL_DATA_W-1:0] acc;
    logic [ADDR_W-1:0]         a_addr;
    logic [ADDR_W-1:0]         b_addr;

    // A[row][k] sits at row*M + k and B_T[col][k] at B_BASE + col*M + k
    assign a_addr = ADDR_W'(cur_job.row) * ADDR_W'(`MATMUL_M) + ADDR_W'(k);
    assign b_addr = ADDR_W'(`MATMUL_B_BASE) + ADDR_W'(cur_job.col) * ADDR_W'(`MATMUL_M)
                    + ADDR_W'(k);

    // the request stays up for the whole fetch state, the arbiter decides when it is served
    assign mem_req.req  = (state == matmul_pkg::ENG_FETCH_A)
                          || (state == matmul_pkg::ENG_FETCH_B);
    assign mem_req.addr = (state == matmul_pkg::ENG_FETCH_B) ? b_addr : a_addr;

    assign busy         = (state != matmul_pkg::ENG_IDLE);
    assign result_ready = (state == matmul_pkg::ENG_HOLD);

    // acc is frozen in HOLD, which keeps the presented result stable until the ack
    assign result.row   = cur_job.row;
    assign result.col   = cur_job.col;
    assign result.value = acc;

    always_ff @(posedge vector_mult_done) begin
        if (reset) begin
            state <= matmul_pkg::ENG_IDLE;
        end else begin
            case (state)
                matmul_pkg::ENG_IDLE: begin
                    // the scheduler only strobes an engine that reports not busy
                    if (job_valid) begin
                        state <= matmul_pkg::ENG_FETCH_A;
                    end
                end
                matmul_pkg::ENG_FETCH_A: begin
                    if (mem_rsp.valid) begin
                        state <= matmul_pkg::ENG_FETCH_B;
                    end
                end
                matmul_pkg::ENG_FETCH_B: begin
                    if (mem_rsp.valid) begin
                        state <= matmul_pkg::ENG_ACCUM;
                    end
                end
                matmul_pkg::ENG_ACCUM: begin
                    if (k == K_W'(`MATMUL_M - 1)) begin
                        state <= matmul_pkg::ENG_HOLD;
                    end else begin
                        state <= matmul_pkg::ENG_FETCH_A;
                    end
                end
                matmul_pkg::ENG_HOLD: begin
                    if (result_ack) begin
                        state <= matmul_pkg::ENG_IDLE;
                    end
                end
                default: begin
                    state <= matmul_pkg::ENG_IDLE;
                end
            endcase
        end
    end

    // datapath registers load with a new job and then step along with the FSM
    always_ff @(posedge vector_mult_done) begin
        if (state == matmul_pkg::ENG_IDLE && job_valid) begin
            cur_job <= job;
            k       <= '0;
            acc     <= '0;
        end
        if (state == matmul_pkg::ENG_FETCH_A && mem_rsp.valid) begin
            a_val <= mem_rsp.data;
        end
        if (state == matmul_pkg::ENG_FETCH_B && mem_rsp.valid) begin
            b_val <= mem_rsp.data;
        end
        if (state == matmul_pkg::ENG_ACCUM) begin
            // the product is truncated to 32 bits, so the sum wraps modulo 2^32
            acc <= acc + a_val * b_val;
            if (k != K_W'(`MATMUL_M - 1)) begin
                k <= k + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module mem_arbiter (
    input  wire logic                       vector_mult_done,
    input  wire logic                       reset,
    input  wire matmul_pkg::mem_read_req_t  req_0,
    input  wire matmul_pkg::mem_read_req_t  req_1,
    output matmul_pkg::mem_read_rsp_t       rsp_0,
    output matmul_pkg::mem_read_rsp_t       rsp_1,
    output logic                            read_en,
    output logic [`MATMUL_ADDR_W-1:0]       read_addr,
    input  wire logic [`MATMUL_DATA_W-1:0]  read_data
);

    // prio set means engine 1 wins the next tie
    logic prio;
    // one read is in flight and rd_owner names the engine it belongs to
    logic rd_pending;
    logic rd_owner;
    logic req_ok_0;
    logic req_ok_1;
    logic grant_0;
    logic grant_1;

    // an engine keeps its request up until its data arrives, so while its own read
    // is in flight the slot is cleared and the other engine can use that cycle
    assign req_ok_0 = req_0.req && !(rd_pending && !rd_owner);
    assign req_ok_1 = req_1.req && !(rd_pending && rd_owner);

    // round robin between the two engines, at most one grant per cycle
    assign grant_0 = req_ok_0 && (!req_ok_1 || !prio);
    assign grant_1 = req_ok_1 && (!req_ok_0 || prio);

    assign read_en   = grant_0 || grant_1;
    assign read_addr = grant_1 ? req_1.addr : req_0.addr;

    always_ff @(posedge vector_mult_done) begin
        if (reset) begin
            prio       <= 1'b0;
            rd_pending <= 1'b0;
            rd_owner   <= 1'b0;
        end else begin
            rd_pending <= read_en;
            if (read_en) begin
                rd_owner <= grant_1;
                // the engine just served drops to the lower priority
                prio     <= grant_0;
            end
        end
    end

    // registered memory data goes back only to the engine that was granted
    assign rsp_0.valid = rd_pending && !rd_owner;
    assign rsp_0.data  = read_data;
    assign rsp_1.valid = rd_pending && rd_owner;
    assign rsp_1.data  = read_data;

endmodule

`default_nettype wire

// File: source/operand_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "matmul_macros.svh"

module operand_mem (
    input  wire logic                       vector_mult_done,
    input  wire logic                       reset,
    input  wire logic                       write_valid,
    input  wire matmul_pkg::mem_write_t     write,
    input  wire logic                       read_en,
    input  wire logic [`MATMUL_ADDR_W-1:0]  read_addr,
    output logic      [`MATMUL_DATA_W-1:0]  read_data
);

    // A occupies the low addresses and B_T follows from MATMUL_B_BASE
    logic [`MATMUL_DATA_W-1:0] mem [`MATMUL_DEPTH];

    // host writes land at the same edge, loads only happen while the multiplier is idle
    always_ff @(posedge vector_mult_done) begin
        if (write_valid) begin
            mem[write.addr] <= write.data;
        end
    end

    // a single read port, so the arbiter has already chosen the one address
    // that is looked up this cycle and the word comes out one cycle later
    always_ff @(posedge vector_mult_done) begin
        if (reset) begin
            read_data <= '0;
        end else if (read_en) begin
            read_data <= mem[read_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/matmul_pkg.sv
`default_nettype none

`include "matmul_macros.svh"

package matmul_pkg;

    // one host write into the operand memory
    typedef struct packed {
        logic [`MATMUL_ADDR_W-1:0] addr;
        logic [`MATMUL_DATA_W-1:0] data;
    } mem_write_t;

    // read request from one engine, held until the arbiter serves it
    typedef struct packed {
        logic                      req;
        logic [`MATMUL_ADDR_W-1:0] addr;
    } mem_read_req_t;

    // read data steered back to the engine that was granted
    typedef struct packed {
        logic                      valid;
        logic [`MATMUL_DATA_W-1:0] data;
    } mem_read_rsp_t;

    // one element of C that an engine has to compute
    typedef struct packed {
        logic [`MATMUL_ROW_W-1:0] row;
        logic [`MATMUL_COL_W-1:0] col;
    } engine_job_t;

    // one finished element of C, tagged with its position
    typedef struct packed {
        logic [`MATMUL_ROW_W-1:0]  row;
        logic [`MATMUL_COL_W-1:0]  col;
        logic [`MATMUL_DATA_W-1:0] value;
    } result_t;

    // both FSMs share this package, so the state names carry a prefix
    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_FETCH_A,
        ENG_FETCH_B,
        ENG_ACCUM,
        ENG_HOLD
    } engine_state_e;

    typedef enum logic [1:0] {
        SCHED_IDLE,
        SCHED_RUN,
        SCHED_FINISH
    } sched_state_e;

endpackage

`default_nettype wire

// File: source/matmul_macros.svh
`ifndef MATMUL_MACROS_SVH
`define MATMUL_MACROS_SVH

// matrix shape: A is L x M, B is M x N, so C is L x N
`define MATMUL_L 3
`define MATMUL_M 4
`define MATMUL_N 2

// every element is a 32-bit unsigned word and all arithmetic wraps
`define MATMUL_DATA_W 32

// operand memory keeps A row-major followed by B_T row-major
`define MATMUL_DEPTH ((`MATMUL_L * `MATMUL_M) + (`MATMUL_N * `MATMUL_M))
`define MATMUL_ADDR_W (($clog2(`MATMUL_DEPTH) > 0) ? $clog2(`MATMUL_DEPTH) : 1)

// index widths stay at least one bit wide so a 1-row or 1-column shape still builds
`define MATMUL_ROW_W (($clog2(`MATMUL_L) > 0) ? $clog2(`MATMUL_L) : 1)
`define MATMUL_COL_W (($clog2(`MATMUL_N) > 0) ? $clog2(`MATMUL_N) : 1)

// first word of B_T, directly after the last word of A
`define MATMUL_B_BASE (`MATMUL_L * `MATMUL_M)

`endif
